//--- build.f
+incdir+hdl
hdl/oramPkg.sv
hdl/initConfigRegs.sv
hdl/widthDownShifter.sv
hdl/dramInitializer.sv
hdl/dramPortMux.sv
hdl/oramDramFront.sv
verification/oramDramFrontTb.sv

//--- hdl/dramInitializer.sv
//------------------------------------------------
// DRAM initializer
// Writes a fresh header into every tree bucket
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "oramSettings.svh"

module dramInitializer (
	input  wire logic                       Clock,
	input  wire logic                       rst,
	input  wire logic                       armed,
	input  wire logic [`IV_WIDTH-1:0]       ivValue,
	output oramPkg::dramCommand             cmd,
	output logic                            cmdValid,
	input  wire logic                       cmdReady,
	output logic      [`DDR_DATA_WIDTH-1:0] headerWord,
	output logic                            headerValid,
	input  wire logic                       headerReady,
	input  wire logic                       flitAccepted,
	output logic                            initDone
);

	//------------------------------------------------
	// Sizes
	//------------------------------------------------

	// Address just past the last bucket
	localparam int LastAddr   = `NUM_BUCKETS * `BUCKET_DR_WORDS;
	localparam int TotalFlits = `NUM_BUCKETS * `FLITS_PER_HEADER;
	localparam int HdrCntW    = $clog2(`NUM_BUCKETS + 1);
	localparam int FlitCntW   = $clog2(TotalFlits + 1);

	logic [`DDR_ADDR_WIDTH-1:0] cmdAddr;
	logic [HdrCntW-1:0]         headerCount;
	logic [FlitCntW-1:0]        flitCount;
	oramPkg::bucketHeader       header;
	logic                       cmdsFinal;
	logic                       flitsFinal;

	//------------------------------------------------
	// Commands
	//------------------------------------------------

	// Address counter doubles as command count
	always_ff @(posedge Clock) begin
		if (rst) begin
			cmdAddr <= '0;
		end else if (cmdValid && cmdReady) begin
			cmdAddr <= cmdAddr + `DDR_ADDR_WIDTH'(`BUCKET_DR_WORDS);
		end
	end

	assign cmdValid    = armed && (cmdAddr != `DDR_ADDR_WIDTH'(LastAddr));
	assign cmd.address = cmdAddr;
	// Init only ever writes
	assign cmd.command = oramPkg::ddrWrite;

	//------------------------------------------------
	// Header words
	//------------------------------------------------
	always_comb begin
		header         = '0;
		// Fresh bucket, nothing valid
		header.valid   = '0;
		header.iv      = ivValue;
		headerWord     = header;
	end

	// One header per bucket, held until taken
	assign headerValid = armed && (headerCount != HdrCntW'(`NUM_BUCKETS));

	always_ff @(posedge Clock) begin
		if (rst) begin
			headerCount <= '0;
		end else if (headerValid && headerReady) begin
			headerCount <= headerCount + 1'b1;
		end
	end

	//------------------------------------------------
	// Flit tracking
	//------------------------------------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			flitCount <= '0;
		end else if (flitAccepted) begin
			flitCount <= flitCount + 1'b1;
		end
	end

	// Look ahead one beat so done lands on the next cycle
	assign flitsFinal = (flitCount == FlitCntW'(TotalFlits)) ||
		(flitAccepted && (flitCount == FlitCntW'(TotalFlits - 1)));

	assign cmdsFinal = (cmdAddr == `DDR_ADDR_WIDTH'(LastAddr)) ||
		(cmdValid && cmdReady &&
		(cmdAddr == `DDR_ADDR_WIDTH'(LastAddr - `BUCKET_DR_WORDS)));

	//------------------------------------------------
	// Completion
	//------------------------------------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			initDone <= 1'b0;
		end else if (flitsFinal && cmdsFinal) begin
			// Stays set, no re-init without reset
			initDone <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/dramPortMux.sv
//------------------------------------------------
// DRAM port mux
// Init owns the DRAM ports until done, then ORAM
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module dramPortMux (
	input  wire logic                initDone,

	// Initializer side
	input  wire oramPkg::dramCommand initCmd,
	input  wire logic                initCmdValid,
	output logic                     initCmdReady,
	input  wire oramPkg::writeFlit   initFlit,
	input  wire logic                initFlitValid,
	output logic                     initFlitReady,

	// ORAM controller side
	input  wire oramPkg::dramCommand oramCmd,
	input  wire logic                oramCmdValid,
	output logic                     oramCmdReady,
	input  wire oramPkg::writeFlit   oramWrite,
	input  wire logic                oramWriteValid,
	output logic                     oramWriteReady,

	// DRAM side
	output oramPkg::dramCommand      dramCmd,
	output logic                     dramCmdValid,
	input  wire logic                dramCmdReady,
	output oramPkg::writeFlit        dramWrite,
	output logic                     dramWriteValid,
	input  wire logic                dramWriteReady
);

	//------------------------------------------------
	// Command stream
	//------------------------------------------------
	assign dramCmd      = initDone ? oramCmd : initCmd;
	assign dramCmdValid = initDone ? oramCmdValid : initCmdValid;

	// Inactive side sees no ready
	assign initCmdReady = ~initDone & dramCmdReady;
	assign oramCmdReady = initDone & dramCmdReady;

	//------------------------------------------------
	// Write data stream
	//------------------------------------------------
	assign dramWrite      = initDone ? oramWrite : initFlit;
	assign dramWriteValid = initDone ? oramWriteValid : initFlitValid;

	// Stalls here never touch the command stream
	assign initFlitReady  = ~initDone & dramWriteReady;
	assign oramWriteReady = initDone & dramWriteReady;

	// ORAM traffic offered early just waits
	// since its ready stays low until done

endmodule

`default_nettype wire

//--- hdl/initConfigRegs.sv
//------------------------------------------------
// Init config registers
// Holds the initial IV, sticky arm bit and status
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "oramSettings.svh"

module initConfigRegs (
	input  wire logic                       Clock,
	input  wire logic                       rst,
	input  wire logic                       cfgWrite,
	input  wire oramPkg::cfgSel             cfgAddr,
	input  wire logic [`CFG_DATA_WIDTH-1:0] cfgWriteData,
	output logic      [`CFG_DATA_WIDTH-1:0] cfgReadData,
	input  wire logic                       initDone,
	output logic      [`IV_WIDTH-1:0]       ivValue,
	output logic                            armed
);

	//------------------------------------------------
	// Register writes
	//------------------------------------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			ivValue <= `IV_INIT_VALUE;
			armed   <= 1'b0;
		end else if (cfgWrite) begin
			case (cfgAddr)
				oramPkg::ivReg: begin
					ivValue <= cfgWriteData[`IV_WIDTH-1:0];
				end
				oramPkg::controlReg: begin
					// Arm is sticky until reset
					armed <= armed | cfgWriteData[0];
				end
				// Status is read-only
				default: ;
			endcase
		end
	end

	//------------------------------------------------
	// Read decode
	//------------------------------------------------
	always_comb begin
		cfgReadData = '0;
		case (cfgAddr)
			oramPkg::ivReg:      cfgReadData[`IV_WIDTH-1:0] = ivValue;
			oramPkg::controlReg: cfgReadData[0] = armed;
			// Bit 0 done, bit 1 armed
			oramPkg::statusReg:  cfgReadData[1:0] = {armed, initDone};
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/oramDramFront.sv
//------------------------------------------------
// ORAM DRAM front end top
// Bucket header init, then hands DRAM to the ORAM
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "oramSettings.svh"

module oramDramFront (
	input  wire logic                       Clock,
	input  wire logic                       rst,
	// Host config
	input  wire logic                       cfgWrite,
	input  wire oramPkg::cfgSel             cfgAddr,
	input  wire logic [`CFG_DATA_WIDTH-1:0] cfgWriteData,
	output logic      [`CFG_DATA_WIDTH-1:0] cfgReadData,
	// ORAM controller
	input  wire oramPkg::dramCommand        oramCmd,
	input  wire logic                       oramCmdValid,
	output logic                            oramCmdReady,
	input  wire oramPkg::writeFlit          oramWrite,
	input  wire logic                       oramWriteValid,
	output logic                            oramWriteReady,
	// DRAM
	output oramPkg::dramCommand             dramCmd,
	output logic                            dramCmdValid,
	input  wire logic                       dramCmdReady,
	output oramPkg::writeFlit               dramWrite,
	output logic                            dramWriteValid,
	input  wire logic                       dramWriteReady,
	output logic                            initDone
);

	logic [`IV_WIDTH-1:0]       ivValue;
	logic                       armed;
	oramPkg::dramCommand        initCmd;
	logic                       initCmdValid, initCmdReady;
	logic [`DDR_DATA_WIDTH-1:0] headerWord;
	logic                       headerValid, headerReady;
	oramPkg::writeFlit          initFlit;
	logic                       initFlitValid, initFlitReady;
	logic                       flitAccepted;

	//------------------------------------------------
	// Host registers
	//------------------------------------------------
	initConfigRegs i_initConfigRegs (
		.Clock(Clock), .rst(rst),
		.cfgWrite(cfgWrite), .cfgAddr(cfgAddr),
		.cfgWriteData(cfgWriteData), .cfgReadData(cfgReadData),
		.initDone(initDone), .ivValue(ivValue), .armed(armed)
	);

	//------------------------------------------------
	// Header generation and narrowing
	//------------------------------------------------

	// Count flits as they leave the shifter
	assign flitAccepted = initFlitValid & initFlitReady;

	dramInitializer i_dramInitializer (
		.Clock(Clock), .rst(rst),
		.armed(armed), .ivValue(ivValue),
		.cmd(initCmd), .cmdValid(initCmdValid), .cmdReady(initCmdReady),
		.headerWord(headerWord), .headerValid(headerValid),
		.headerReady(headerReady),
		.flitAccepted(flitAccepted), .initDone(initDone)
	);

	widthDownShifter i_widthDownShifter (
		.Clock(Clock), .rst(rst),
		.inWord(headerWord), .inValid(headerValid), .inReady(headerReady),
		.outFlit(initFlit), .outValid(initFlitValid), .outReady(initFlitReady)
	);

	//------------------------------------------------
	// Port ownership
	//------------------------------------------------
	dramPortMux i_dramPortMux (
		.initDone(initDone),
		.initCmd(initCmd), .initCmdValid(initCmdValid), .initCmdReady(initCmdReady),
		.initFlit(initFlit), .initFlitValid(initFlitValid),
		.initFlitReady(initFlitReady),
		.oramCmd(oramCmd), .oramCmdValid(oramCmdValid), .oramCmdReady(oramCmdReady),
		.oramWrite(oramWrite), .oramWriteValid(oramWriteValid),
		.oramWriteReady(oramWriteReady),
		.dramCmd(dramCmd), .dramCmdValid(dramCmdValid), .dramCmdReady(dramCmdReady),
		.dramWrite(dramWrite), .dramWriteValid(dramWriteValid),
		.dramWriteReady(dramWriteReady)
	);

endmodule

`default_nettype wire

//--- hdl/oramPkg.sv
//------------------------------------------------
// ORAM front end shared types
//------------------------------------------------
`default_nettype none

`include "oramSettings.svh"

package oramPkg;

	// DDR command encodings
	typedef enum logic [`DDR_CMD_WIDTH-1:0] {
		ddrWrite = 3'b000,
		ddrRead  = 3'b001,
		ddrNop   = 3'b111
	} ddrCmd;

	// One command beat on the DRAM command port
	typedef struct packed {
		logic [`DDR_ADDR_WIDTH-1:0] address;
		ddrCmd                      command;
	} dramCommand;

	// Unused upper bits of a header word
	localparam int headerPadWidth = `DDR_DATA_WIDTH - `VALID_BITS - `IV_WIDTH;

	// Bucket header layout, iv in the low bits
	typedef struct packed {
		logic [headerPadWidth-1:0] padding;
		logic [`VALID_BITS-1:0]    valid;
		logic [`IV_WIDTH-1:0]      iv;
	} bucketHeader;

	// Narrow write data beat
	typedef struct packed {
		logic [`BED_WIDTH-1:0] data;
	} writeFlit;

	// Host register map
	typedef enum logic [`CFG_ADDR_WIDTH-1:0] {
		ivReg      = 2'd0,
		controlReg = 2'd1,
		statusReg  = 2'd2
	} cfgSel;

endpackage

`default_nettype wire

//--- hdl/oramSettings.svh
//------------------------------------------------
// ORAM DRAM front end geometry
// Tree, bucket and bus sizes for the init path
//------------------------------------------------
`ifndef ORAM_SETTINGS_SVH
`define ORAM_SETTINGS_SVH

// Tree shape
`define ORAM_LEVELS         3
`define NUM_SUBTREES        2
// Bucket slots plus one wasted bucket per subtree
`define NUM_BUCKETS         ((1 << (`ORAM_LEVELS + 1)) + `NUM_SUBTREES)
`define BUCKET_DR_WORDS     4

// DDR side
`define DDR_ADDR_WIDTH      16
`define DDR_CMD_WIDTH       3
`define DDR_DATA_WIDTH      64

// Bucket encryption data path
`define BED_WIDTH           16
`define FLITS_PER_HEADER    ((`DDR_DATA_WIDTH + `BED_WIDTH - 1) / `BED_WIDTH)

// Header fields
`define IV_WIDTH            16
`define IV_INIT_VALUE       16'h0000
`define VALID_BITS          4

// Host config port
`define CFG_ADDR_WIDTH      2
`define CFG_DATA_WIDTH      16

`endif

//--- hdl/widthDownShifter.sv
//------------------------------------------------
// Width down shifter
// Takes one DDR-wide word, emits narrow flits LSB first
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "oramSettings.svh"

module widthDownShifter (
	input  wire logic                       Clock,
	input  wire logic                       rst,
	input  wire logic [`DDR_DATA_WIDTH-1:0] inWord,
	input  wire logic                       inValid,
	output logic                            inReady,
	output oramPkg::writeFlit               outFlit,
	output logic                            outValid,
	input  wire logic                       outReady
);

	// Enough bits to hold a full flit count
	localparam int CntWidth = $clog2(`FLITS_PER_HEADER + 1);

	logic [`DDR_DATA_WIDTH-1:0] shiftReg;
	logic [CntWidth-1:0]        flitsLeft;
	logic                       wordTaken;
	logic                       flitTaken;

	//------------------------------------------------
	// Handshakes
	//------------------------------------------------

	// Only load when fully drained
	assign inReady   = (flitsLeft == '0);
	assign outValid  = (flitsLeft != '0);

	assign wordTaken = inValid & inReady;
	assign flitTaken = outValid & outReady;

	// Lowest slice is always the current flit
	assign outFlit.data = shiftReg[`BED_WIDTH-1:0];

	//------------------------------------------------
	// Flit counter
	//------------------------------------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			flitsLeft <= '0;
		end else if (wordTaken) begin
			// First flit valid next cycle
			flitsLeft <= CntWidth'(`FLITS_PER_HEADER);
		end else if (flitTaken) begin
			flitsLeft <= flitsLeft - 1'b1;
		end
	end

	//------------------------------------------------
	// Shift register
	//------------------------------------------------
	always_ff @(posedge Clock) begin
		if (wordTaken) begin
			shiftReg <= inWord;
		end else if (flitTaken) begin
			// Drop the sent flit, next one moves down
			shiftReg <= shiftReg >> `BED_WIDTH;
		end
	end

	// Load and shift never overlap
	// since input ready implies no flit is valid

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Compile the ORAM DRAM front end testbench with Verilator and run it.
# A $fatal in the testbench gives a non-zero exit status.
verilator --binary --timing -f build.f --top-module oramDramFrontTb -o simv \
	&& ./obj_dir/simv \
	|| { echo "Simulation run reported an error"; exit 1; }

//--- verification/oramDramFrontTb.sv
//------------------------------------------------
// ORAM DRAM front end testbench
// Phase table, random DRAM back-pressure, scoreboard
//------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "oramSettings.svh"

module oramDramFrontTb;

	localparam int TotalFlits = `NUM_BUCKETS * `FLITS_PER_HEADER;
	// Run limit scaled from the init traffic
	localparam int CycleLimit = 4 * (TotalFlits + `NUM_BUCKETS) + 200;

	// One phase of the test sequence
	typedef struct packed {
		logic                       wr;
		oramPkg::cfgSel             addr;
		logic [`CFG_DATA_WIDTH-1:0] data;
		logic [`CFG_DATA_WIDTH-1:0] expRead;
		logic                       oramOffers;
		logic [15:0]                waitCycles;
		logic                       runToDone;
	} phaseEntry;

	logic                       Clock = 1'b0;
	logic                       rst;
	logic                       cfgWrite;
	oramPkg::cfgSel             cfgAddr;
	logic [`CFG_DATA_WIDTH-1:0] cfgWriteData;
	logic [`CFG_DATA_WIDTH-1:0] cfgReadData;
	oramPkg::dramCommand        oramCmd = '0;
	logic                       oramCmdValid = 1'b0;
	logic                       oramCmdReady;
	oramPkg::writeFlit          oramWrite = '0;
	logic                       oramWriteValid = 1'b0;
	logic                       oramWriteReady;
	oramPkg::dramCommand        dramCmd;
	logic                       dramCmdValid;
	logic                       dramCmdReady = 1'b0;
	oramPkg::writeFlit          dramWrite;
	logic                       dramWriteValid;
	logic                       dramWriteReady = 1'b0;
	logic                       initDone;

	// Scoreboard and sequencing state
	phaseEntry          phaseTable [5];
	logic               oramOffers = 1'b0;
	logic               armIssued = 1'b0;
	logic [15:0]        tableIv = `IV_INIT_VALUE;
	logic               oramCmdTaken = 1'b0;
	logic               oramWriteTaken = 1'b0;
	logic               doneSeen = 1'b0;
	logic [7:0]         cmdSeq = 8'h00;
	logic [7:0]         writeSeq = 8'h00;
	logic [31:0]        lfsrState = 32'h9bad;
	int                 cmdCount = 0;
	int                 flitCount = 0;
	int                 oramCmdPassed = 0;
	int                 oramWritePassed = 0;
	int                 cycleCount = 0;

	oramDramFront i_oramDramFront (
		.Clock(Clock), .rst(rst),
		.cfgWrite(cfgWrite), .cfgAddr(cfgAddr),
		.cfgWriteData(cfgWriteData), .cfgReadData(cfgReadData),
		.oramCmd(oramCmd), .oramCmdValid(oramCmdValid), .oramCmdReady(oramCmdReady),
		.oramWrite(oramWrite), .oramWriteValid(oramWriteValid),
		.oramWriteReady(oramWriteReady),
		.dramCmd(dramCmd), .dramCmdValid(dramCmdValid), .dramCmdReady(dramCmdReady),
		.dramWrite(dramWrite), .dramWriteValid(dramWriteValid),
		.dramWriteReady(dramWriteReady),
		.initDone(initDone)
	);

	always #4 Clock = ~Clock;

	//------------------------------------------------
	// Helpers
	//------------------------------------------------

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic stopOnError();
		$display("Verification failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic reportMismatch(input string sigName, input logic [63:0] expVal,
		input logic [63:0] actVal);
		$display("FAIL time=%0t %s expected=0x%0h actual=0x%0h",
			$time, sigName, expVal, actVal);
		stopOnError();
	endtask

	task automatic reportProblem(input string msg);
		$display("%s at time %0t", msg, $time);
		stopOnError();
	endtask

	//------------------------------------------------
	// DRAM back-pressure and ORAM traffic source
	//------------------------------------------------
	always @(posedge Clock) begin
		#1;
		// One LFSR step per ready bit
		lfsrState = lfsrStep(lfsrState);
		dramCmdReady = lfsrState[0];
		lfsrState = lfsrStep(lfsrState);
		dramWriteReady = lfsrState[0];
		if (oramCmdTaken)
			cmdSeq = cmdSeq + 8'd1;
		if (oramWriteTaken)
			writeSeq = writeSeq + 8'd1;
		// Valid held until accepted
		oramCmdValid = oramOffers | (oramCmdValid & ~oramCmdTaken);
		oramWriteValid = oramOffers | (oramWriteValid & ~oramWriteTaken);
		oramCmd.address = {8'hf0, cmdSeq};
		oramCmd.command = oramPkg::ddrRead;
		oramWrite.data = {8'hbe, writeSeq};
	end

	//------------------------------------------------
	// Monitor sampled mid-cycle where all is stable
	//------------------------------------------------
	always @(negedge Clock) begin : monitor
		logic [63:0] expWord;
		logic [15:0] expFlit;
		logic [15:0] expAddr;
		oramCmdTaken = oramCmdValid & oramCmdReady;
		oramWriteTaken = oramWriteValid & oramWriteReady;
		if (!rst) begin
			cycleCount++;
			if (cycleCount > CycleLimit)
				reportProblem("Timeout, the run did not finish within the cycle limit");
			// Idle until armed
			if (!armIssued) begin
				assert (!dramCmdValid) else reportMismatch("dramCmdValid", 0, 64'(dramCmdValid));
				assert (!dramWriteValid)
					else reportMismatch("dramWriteValid", 0, 64'(dramWriteValid));
				assert (!initDone) else reportMismatch("initDone", 0, 64'(initDone));
			end
			if (doneSeen) begin
				assert (initDone) else reportMismatch("initDone", 1, 64'(initDone));
			end else if (initDone) begin
				// First cycle of done
				doneSeen = 1'b1;
				assert (cmdCount == `NUM_BUCKETS)
					else reportMismatch("command count", `NUM_BUCKETS, 64'(cmdCount));
				assert (flitCount == TotalFlits)
					else reportMismatch("flit count", TotalFlits, 64'(flitCount));
			end
			// Done lands one cycle after the last init transfer
			assert (initDone || cmdCount != `NUM_BUCKETS || flitCount != TotalFlits)
				else reportMismatch("initDone", 1, 64'(initDone));
			if (!initDone) begin
				assert (!oramCmdReady) else reportMismatch("oramCmdReady", 0, 64'(oramCmdReady));
				assert (!oramWriteReady)
					else reportMismatch("oramWriteReady", 0, 64'(oramWriteReady));
				if (dramCmdValid && dramCmdReady) begin
					expAddr = 16'(cmdCount * `BUCKET_DR_WORDS);
					assert (cmdCount < `NUM_BUCKETS)
						else reportProblem("More init commands than buckets");
					assert (dramCmd.address == expAddr)
						else reportMismatch("dramCmd.address", 64'(expAddr), 64'(dramCmd.address));
					assert (dramCmd.command == oramPkg::ddrWrite)
						else reportMismatch("dramCmd.command", 64'(oramPkg::ddrWrite),
							64'(dramCmd.command));
					cmdCount++;
				end
				if (dramWriteValid && dramWriteReady) begin
					// Header is zero padding, zero valid, iv at the bottom
					expWord = 64'(tableIv);
					expFlit = 16'(expWord >> (`BED_WIDTH * (flitCount % `FLITS_PER_HEADER)));
					assert (flitCount < TotalFlits)
						else reportProblem("More init flits than the headers hold");
					assert (dramWrite.data == expFlit)
						else reportMismatch("dramWrite.data", 64'(expFlit), 64'(dramWrite.data));
					flitCount++;
				end
			end else begin
				// ORAM owns the port after done
				assert (dramCmdValid == oramCmdValid)
					else reportMismatch("dramCmdValid", 64'(oramCmdValid), 64'(dramCmdValid));
				assert (dramCmd == oramCmd)
					else reportMismatch("dramCmd", 64'(oramCmd), 64'(dramCmd));
				assert (oramCmdReady == dramCmdReady)
					else reportMismatch("oramCmdReady", 64'(dramCmdReady), 64'(oramCmdReady));
				assert (dramWriteValid == oramWriteValid)
					else reportMismatch("dramWriteValid", 64'(oramWriteValid),
						64'(dramWriteValid));
				assert (dramWrite == oramWrite)
					else reportMismatch("dramWrite", 64'(oramWrite), 64'(dramWrite));
				assert (oramWriteReady == dramWriteReady)
					else reportMismatch("oramWriteReady", 64'(dramWriteReady),
						64'(oramWriteReady));
				if (oramCmdTaken)
					oramCmdPassed++;
				if (oramWriteTaken)
					oramWritePassed++;
			end
		end
	end

	//------------------------------------------------
	// Phase sequencer
	//------------------------------------------------
	initial begin : sequencer
		phaseEntry e;
		rst = 1'b1;
		cfgWrite = 1'b0;
		cfgAddr = oramPkg::ivReg;
		cfgWriteData = '0;
		// Idle with ORAM traffic offered and status reading zero
		phaseTable[0] = '{1'b0, oramPkg::statusReg, 16'h0000, 16'h0000, 1'b1, 16'd20, 1'b0};
		// IV write and readback
		phaseTable[1] = '{1'b1, oramPkg::ivReg, 16'hc3a5, 16'hc3a5, 1'b0, 16'd2, 1'b0};
		// Status is read-only
		phaseTable[2] = '{1'b1, oramPkg::statusReg, 16'h0003, 16'h0000, 1'b0, 16'd2, 1'b0};
		// Arm and run to done
		phaseTable[3] = '{1'b1, oramPkg::controlReg, 16'h0001, 16'h0001, 1'b1, 16'd0, 1'b1};
		// Pass-through after done with done and armed set
		phaseTable[4] = '{1'b0, oramPkg::statusReg, 16'h0000, 16'h0003, 1'b1, 16'd40, 1'b0};

		repeat (8) @(posedge Clock);
		#1 rst = 1'b0;

		for (int i = 0; i < 5; i++) begin
			e = phaseTable[i];
			@(posedge Clock);
			#1;
			cfgAddr = e.addr;
			cfgWriteData = e.data;
			cfgWrite = e.wr;
			oramOffers = e.oramOffers;
			if (e.wr) begin
				@(posedge Clock);
				#1;
				cfgWrite = 1'b0;
				if (e.addr == oramPkg::controlReg)
					armIssued = 1'b1;
				if (e.addr == oramPkg::ivReg)
					tableIv = e.data;
			end
			if (e.runToDone) begin
				while (!initDone)
					@(posedge Clock);
			end else begin
				repeat (int'(e.waitCycles)) @(posedge Clock);
			end
			@(negedge Clock);
			assert (cfgReadData == e.expRead)
				else reportMismatch("cfgReadData", 64'(e.expRead), 64'(cfgReadData));
		end

		if (cmdCount == `NUM_BUCKETS && flitCount == TotalFlits &&
			oramCmdPassed > 0 && oramWritePassed > 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			reportProblem("Init traffic incomplete or no ORAM traffic passed after done");
		end
	end

endmodule

`default_nettype wire
